/* build.f */
source/board_pkg.sv
source/video_if.sv
source/slow_tick_gen.sv
source/vga_timing.sv
source/seven_seg_mux.sv
source/i2s_audio_out.sv
source/lab_top.sv
source/board_top.sv
bench/tb_clock_gen.sv
bench/board_top_chk.sv
bench/board_top_tb.sv

/* bench/board_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;

    localparam int clk_mhz     = 2;
    localparam int pixel_mhz   = 1;
    localparam int tick_hz     = 200000;
    localparam int bclk_div    = 2;
    localparam int tick_period = clk_mhz * 1_000_000 / tick_hz;  // 10 cycles
    localparam int pix_div     = clk_mhz / pixel_mhz;
    localparam int line_cycles = 800 * pix_div;
    localparam int frame_cycles = 525 * line_cycles;
    localparam int audio_frame = 32 * 2 * bclk_div;              // Cycles per I2S frame

    localparam int kind_run   = 0;  // Run cycles, then check LEDs and digits
    localparam int kind_line  = 1;
    localparam int kind_frame = 2;
    localparam int kind_audio = 3;

    // Active high abcdefgh for hex 0 to f
    localparam logic [7:0] seg_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    typedef struct packed {
        logic [3:0]  key;
        logic [31:0] cycles;
        logic [1:0]  kind;
    } row_t;

    logic       clk;
    logic       rst;
    logic [3:0] key;
    logic [3:0] led;
    logic [7:0] seg;
    logic [3:0] dig;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_r;
    logic       vga_g;
    logic       vga_b;
    logic       mclk;
    logic       bclk;
    logic       lrclk;
    logic       sdata;

    row_t        rows [$];
    int          n_edges;       // Clock edges since reset release
    logic        m_tick;
    logic [15:0] m_count;
    logic [15:0] m_prev_count;  // Counter before the last edge
    logic [3:0]  m_led;         // Predicted led pins
    logic        cur_hsync;
    logic        prev_hsync;
    logic        cur_vsync;
    logic        prev_vsync;
    logic        cur_bclk;
    logic        prev_bclk;
    logic        cur_lrclk;
    logic        prev_lrclk;
    logic        cur_mclk;
    logic        prev_mclk;
    logic        cur_sdata;
    logic        cur_r;
    logic        cur_g;
    logic        cur_b;
    logic        timed_out;
    int          row_errors;
    int          errors;
    int          failed_rows;
    int          checks;
    int          bound_errors;
    int          guard;

    tb_clock_gen #(.period_ns(4), .reset_cycles(10)) tb_clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    board_top #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz),
        .tick_hz   (tick_hz),
        .bclk_div  (bclk_div)
    ) board_top_inst (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .led       (led),
        .seg       (seg),
        .dig       (dig),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .mclk      (mclk),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata)
    );

    bind board_top board_top_chk board_top_chk_inst (.*);

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic add_row(input logic [3:0] k, input int cycles, input int kind);
        row_t r;
        r.key    = k;
        r.cycles = cycles;
        r.kind   = kind;
        rows.push_back(r);
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            kind_run:   return "run";
            kind_line:  return "line";
            kind_frame: return "frame";
            default:    return "audio";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            row_errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Model updates at the rising edge and outputs are sampled at the falling edge
    task automatic step();
        @(posedge clk);
        m_prev_count = m_count;
        n_edges++;
        m_led = ~(m_count[3:0] ^ ~key);
        if (!key[3]) begin
            m_count = 16'd0;  // key[3] pressed
        end else if (m_tick) begin
            m_count = m_count + 16'd1;
        end
        m_tick = (n_edges % tick_period) == 0;
        @(negedge clk);
        prev_hsync = cur_hsync;
        prev_vsync = cur_vsync;
        prev_bclk  = cur_bclk;
        prev_lrclk = cur_lrclk;
        prev_mclk  = cur_mclk;
        cur_hsync  = vga_hsync;
        cur_vsync  = vga_vsync;
        cur_bclk   = bclk;
        cur_lrclk  = lrclk;
        cur_mclk   = mclk;
        cur_sdata  = sdata;
        cur_r      = vga_r;
        cur_g      = vga_g;
        cur_b      = vga_b;
    endtask

    task automatic check_digits();
        int n_low;
        int active;
        int shown;
        n_low  = 0;
        active = 0;
        shown  = -1;
        for (int i = 0; i < 4; i++) begin
            if (!dig[i]) begin
                n_low++;
                active = i;
            end
        end
        for (int v = 0; v < 16; v++) begin
            if (seg_table[v] == ~seg) shown = v;
        end
        checks++;
        assert (n_low == 1) else begin
            row_errors++;
            $display("dig 0x%0h does not select exactly one digit", dig);
        end
        checks++;
        assert (shown >= 0) else begin
            row_errors++;
            $display("seg 0x%0h does not show a hex digit", seg);
        end
        if (n_low == 1 && shown >= 0) begin
            check_value($sformatf("seg on digit %0d", active), shown,
                        m_count[active*4 +: 4]);
        end
    endtask

    // ------------------------------
    // Video and audio measurements
    // ------------------------------

    task automatic measure_line();
        int          wait_cnt;
        int          period;
        int          low;
        int          n_r;
        int          n_g;
        int          n_b;
        logic [1:0]  pat;
        pat      = ~key[1:0];  // Switches share the key pins
        wait_cnt = 0;
        period   = 0;
        low      = 0;
        n_r      = 0;
        n_g      = 0;
        n_b      = 0;
        do begin
            step();
            wait_cnt++;
        end while (!(prev_hsync && !cur_hsync) && wait_cnt < 2 * line_cycles);
        if (!(prev_hsync && !cur_hsync)) begin
            report_timeout("no falling hsync edge");
            return;
        end
        do begin
            step();
            period++;
            if (!cur_hsync) low++;
            if (cur_r) n_r++;
            if (cur_g) n_g++;
            if (cur_b) n_b++;
        end while (!(prev_hsync && !cur_hsync) && period < 2 * line_cycles);
        if (!(prev_hsync && !cur_hsync)) begin
            report_timeout("hsync did not fall again");
            return;
        end
        check_value("hsync period", period, line_cycles);
        check_value("hsync low cycles", low, 96 * pix_div);
        // Stripes and checker light half of the 640 pixels, solid all of them
        check_value("vga_r cycles", n_r, pat == 2'd0 ? 320 * pix_div : 0);
        check_value("vga_g cycles", n_g, pat == 2'd1 ? 320 * pix_div : 0);
        check_value("vga_b cycles", n_b, pat == 2'd2 ? 640 * pix_div : 0);
    endtask

    task automatic measure_frame();
        int wait_cnt;
        int period;
        int low;
        int lines;
        wait_cnt = 0;
        period   = 0;
        low      = 0;
        lines    = 0;
        do begin
            step();
            wait_cnt++;
        end while (!(prev_vsync && !cur_vsync) && wait_cnt < 2 * frame_cycles);
        if (!(prev_vsync && !cur_vsync)) begin
            report_timeout("no falling vsync edge");
            return;
        end
        do begin
            step();
            period++;
            if (!cur_vsync) low++;
            if (prev_hsync && !cur_hsync) lines++;
        end while (!(prev_vsync && !cur_vsync) && period < 2 * frame_cycles);
        if (!(prev_vsync && !cur_vsync)) begin
            report_timeout("vsync did not fall again");
            return;
        end
        check_value("vsync period", period, frame_cycles);
        check_value("vsync low cycles", low, 2 * line_cycles);
        check_value("hsync pulses per frame", lines, 525);
    endtask

    task automatic capture_audio();
        int          wait_cnt;
        int          nbits;
        int          mclk_toggles;
        logic [15:0] word;
        logic [15:0] expected;
        wait_cnt     = 0;
        nbits        = -1;  // First rising bclk still carries the right LSB
        mclk_toggles = 0;
        word         = 16'h0;
        do begin
            step();
            wait_cnt++;
        end while (!(prev_lrclk && !cur_lrclk) && wait_cnt < 2 * audio_frame);
        if (!(prev_lrclk && !cur_lrclk)) begin
            report_timeout("no falling lrclk edge");
            return;
        end
        // Sample latched on the edge that dropped lrclk
        expected = m_prev_count[0] ? 16'h4000 : 16'hc000;
        wait_cnt = 0;
        while (nbits < 16 && wait_cnt < audio_frame) begin
            step();
            wait_cnt++;
            if (cur_mclk != prev_mclk) mclk_toggles++;
            if (!prev_bclk && cur_bclk) begin
                if (nbits >= 0) word = {word[14:0], cur_sdata};
                nbits++;
            end
        end
        if (nbits < 16) begin
            report_timeout("bclk stopped before 16 left-channel bits");
            return;
        end
        check_value("sdata word", word, expected);
        check_value("mclk toggles", mclk_toggles, wait_cnt);  // One per clock
    endtask

    // ------------------------------
    // Stimulus table and main loop
    // ------------------------------

    initial begin
        key          = 4'hf;  // No key pressed
        n_edges      = 0;
        m_tick       = 1'b0;
        m_count      = 16'd0;
        m_prev_count = 16'd0;
        m_led        = 4'hf;
        cur_hsync    = 1'b1;
        prev_hsync   = 1'b1;
        cur_vsync    = 1'b1;
        prev_vsync   = 1'b1;
        cur_bclk     = 1'b0;
        prev_bclk    = 1'b0;
        cur_lrclk    = 1'b0;
        prev_lrclk   = 1'b0;
        cur_mclk     = 1'b0;
        prev_mclk    = 1'b0;
        timed_out    = 1'b0;
        errors       = 0;
        failed_rows  = 0;
        checks       = 0;

        add_row(4'hf, 5, kind_run);     // Before the first tick
        add_row(4'hf, 10, kind_run);
        add_row(4'hf, 37, kind_run);
        add_row(4'he, 21, kind_run);    // key[0] pressed
        add_row(4'h9, 13, kind_run);    // key[1] and key[2]
        add_row(4'h7, 15, kind_run);    // key[3] clears
        add_row(4'h7, 40, kind_run);    // Frozen at zero
        add_row(4'hf, 3, kind_run);     // Released before the next tick
        add_row(4'hf, 30, kind_run);
        add_row(4'hf, 150, kind_run);
        add_row(4'hf, 0, kind_audio);
        add_row(4'hf, 0, kind_audio);
        add_row(4'hf, 0, kind_audio);
        add_row(4'h7, 0, kind_audio);   // Held at zero gives minus
        add_row(4'hd, 0, kind_line);    // Solid
        add_row(4'hf, 0, kind_line);    // Stripes
        add_row(4'hc, 0, kind_line);    // Off
        add_row(4'he, 0, kind_line);    // Checker
        add_row(4'hf, 64, kind_run);
        add_row(4'hf, 0, kind_frame);
        add_row(4'hf, 17, kind_run);
        add_row(4'hf, 17, kind_run);
        add_row(4'hf, 33, kind_run);

        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (rst && guard < 100);
        if (rst) report_timeout("reset was never released");
        // This edge is the first one without reset
        m_prev_count = m_count;
        n_edges      = 1;
        m_led        = ~(m_count[3:0] ^ ~key);
        @(negedge clk);

        foreach (rows[i]) begin
            if (timed_out) break;
            row_errors = 0;
            key        = rows[i].key;
            case (rows[i].kind)
                kind_run: begin
                    for (int c = 0; c < rows[i].cycles; c++) begin
                        step();
                    end
                end
                kind_line:  measure_line();
                kind_frame: measure_frame();
                default:    capture_audio();
            endcase
            check_value("led", led, m_led);
            check_digits();
            errors += row_errors;
            if (row_errors != 0) failed_rows++;
            $display("row %0d %s key %h count 0x%h: %0d errors", i, kind_name(rows[i].kind),
                     rows[i].key, m_count, row_errors);
        end

        bound_errors = board_top_inst.board_top_chk_inst.fail_count;
        $display("%0d rows, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 rows.size(), failed_rows, checks, errors, bound_errors);
        if (errors == 0 && failed_rows == 0 && bound_errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/board_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module board_top_chk (
    input logic                          clk,
    input logic                          rst,
    input logic [board_pkg::w_digit-1:0] dig,
    input logic                          vga_hsync,
    input logic                          vga_vsync,
    input logic                          vga_r,
    input logic                          vga_g,
    input logic                          vga_b,
    input logic                          bclk,
    input logic                          lrclk
);

    int fail_count = 0;  // Read by the testbench at the end

    // ------------------------------
    // Display and video
    // ------------------------------

    one_digit_active: assert property (@(posedge clk) disable iff (rst) $onehot(~dig))
        else begin
            fail_count++;
            $error("dig 0x%0h does not select exactly one digit", dig);
        end

    // Either sync pulse means the beam is outside the visible area
    blank_in_sync: assert property (@(posedge clk) disable iff (rst)
        (!vga_hsync || !vga_vsync) |-> !(vga_r || vga_g || vga_b))
        else begin
            fail_count++;
            $error("colour high while a sync pulse is active");
        end

    // ------------------------------
    // Audio
    // ------------------------------

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(lrclk) |-> $fell(bclk))
        else begin
            fail_count++;
            $error("lrclk changed away from a falling bclk edge");
        end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // Released on a falling edge so the first edge without reset is clean
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* source/board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25,
    parameter int tick_hz   = 1,
    parameter int bclk_div  = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [3:0]                    key,        // Active low
    output logic [3:0]                    led,        // Active low
    output logic [7:0]                    seg,        // Active low
    output logic [board_pkg::w_digit-1:0] dig,        // Active low
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic                          vga_r,
    output logic                          vga_g,
    output logic                          vga_b,
    output logic                          mclk,
    output logic                          bclk,
    output logic                          lrclk,
    output logic                          sdata
);
    import board_pkg::*;

    logic               tick;
    logic [3:0]         lab_led;
    logic [7:0]         abcdefgh;
    logic [w_digit-1:0] lab_digit;
    logic               red;
    logic               green;
    logic               blue;
    logic [15:0]        sound;

    video_if video ();

    // ------------------------------
    // Interface blocks
    // ------------------------------

    slow_tick_gen #(
        .clk_mhz (clk_mhz),
        .tick_hz (tick_hz)
    ) slow_tick_gen_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    vga_timing #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz)
    ) vga_timing_inst (
        .clk   (clk),
        .rst   (rst),
        .video (video)
    );

    i2s_audio_out #(
        .bclk_div (bclk_div)
    ) i2s_audio_out_inst (
        .clk    (clk),
        .rst    (rst),
        .sample (sound),
        .mclk   (mclk),
        .bclk   (bclk),
        .lrclk  (lrclk),
        .sdata  (sdata)
    );

    // ------------------------------
    // Example lab
    // ------------------------------

    lab_top lab_top_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .key      (~key),  // Pressed key reads as one
        .sw       (~key),  // Switches share the key pins
        .video    (video),
        .led      (lab_led),
        .abcdefgh (abcdefgh),
        .digit    (lab_digit),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .sound    (sound)
    );

    assign led = ~lab_led;
    assign seg = ~abcdefgh;
    assign dig = ~lab_digit;

    assign vga_hsync = video.hsync;
    assign vga_vsync = video.vsync;

    assign vga_r = video.display_on & red;  // Blank outside visible area
    assign vga_g = video.display_on & green;
    assign vga_b = video.display_on & blue;

endmodule

`default_nettype wire

/* source/lab_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lab_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tick,
    input  logic [3:0]                    key,
    input  logic [3:0]                    sw,
    video_if.sink                         video,
    output logic [3:0]                    led,
    output logic [7:0]                    abcdefgh,
    output logic [board_pkg::w_digit-1:0] digit,
    output logic                          red,
    output logic                          green,
    output logic                          blue,
    output logic [15:0]                   sound
);
    import board_pkg::*;

    logic [15:0] count;
    pattern_e    pattern;

    // ------------------------------
    // Tick counter and LEDs
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (key[3]) begin
            count <= '0;  // Held clear
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else begin
            led <= count[3:0] ^ key;
        end
    end

    seven_seg_mux seven_seg_mux_inst (
        .clk      (clk),
        .rst      (rst),
        .value    (count),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ------------------------------
    // Test patterns
    // ------------------------------

    assign pattern = pattern_e'(sw[1:0]);

    always_comb begin
        red   = 1'b0;
        green = 1'b0;
        blue  = 1'b0;
        case (pattern)
            pattern_stripes: red   = video.x[5];                // 32 pixel bars
            pattern_checker: green = video.x[5] ^ video.y[5];
            pattern_solid:   blue  = 1'b1;
            pattern_off: begin
                red   = 1'b0;
                green = 1'b0;
                blue  = 1'b0;
            end
        endcase
    end

    // Square tone of plus or minus 0x4000
    assign sound = count[0] ? 16'h4000 : 16'hc000;

endmodule

`default_nettype wire

/* source/i2s_audio_out.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out #(
    parameter int bclk_div = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] sample,
    output logic        mclk,
    output logic        bclk,
    output logic        lrclk,
    output logic        sdata
);
    import board_pkg::*;

    localparam int w_div = bclk_div > 1 ? $clog2(bclk_div) : 1;

    i2s_state_e       state;
    logic [w_div-1:0] div_cnt;
    logic             bclk_tick;
    logic             bclk_fall;
    logic [3:0]       bit_cnt;   // Slot within the current half
    logic             half_end;
    logic [15:0]      sample_q;
    logic [15:0]      shift_q;

    assign bclk_tick = div_cnt == w_div'(bclk_div - 1);
    assign bclk_fall = bclk_tick && bclk;  // bclk about to go low
    assign half_end  = bit_cnt == 4'd15;

    always_ff @(posedge clk) begin
        if (rst) begin
            mclk    <= 1'b0;
            bclk    <= 1'b0;
            div_cnt <= '0;
        end else begin
            mclk <= ~mclk;
            if (bclk_tick) begin
                div_cnt <= '0;
                bclk    <= ~bclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Frame FSM, all changes on falling bclk
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= i2s_idle;
            bit_cnt <= '0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            case (state)
                i2s_idle: begin
                    state   <= i2s_left;
                    bit_cnt <= '0;
                end
                i2s_left: begin
                    sdata <= shift_q[15];
                    if (half_end) begin
                        state <= i2s_right;
                        lrclk <= 1'b1;
                    end
                end
                i2s_right: begin
                    sdata <= shift_q[15];
                    if (half_end) begin
                        state <= i2s_left;
                        lrclk <= 1'b0;
                    end
                end
                default: state <= i2s_idle;
            endcase
        end
    end

    // MSB leaves one bclk after the load, LSB goes out with the lrclk edge
    always_ff @(posedge clk) begin
        if (bclk_fall) begin
            if (state == i2s_idle || (state == i2s_right && half_end)) begin
                sample_q <= sample;  // Frame start
                shift_q  <= sample;
            end else if (state == i2s_left && half_end) begin
                shift_q <= sample_q;  // Same word on right channel
            end else begin
                shift_q <= shift_q << 1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/seven_seg_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module seven_seg_mux (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [15:0]                   value,
    output logic [7:0]                    abcdefgh,
    output logic [board_pkg::w_digit-1:0] digit
);
    import board_pkg::*;

    localparam int w_scan = $clog2(seg_scan_cycles);

    logic [w_scan-1:0]  scan_cnt;
    logic [w_digit-1:0] sel;     // One-hot digit select
    logic [3:0]         nibble;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            sel      <= w_digit'(1);
        end else if (scan_cnt == w_scan'(seg_scan_cycles - 1)) begin
            scan_cnt <= '0;
            sel      <= {sel[w_digit-2:0], sel[w_digit-1]};  // Rotate to next digit
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        nibble = 4'h0;
        for (int i = 0; i < w_digit; i++) begin
            if (sel[i]) begin
                nibble = value[i*4 +: 4];
            end
        end
    end

    // Hex to segments, dot off
    always_comb begin
        abcdefgh = 8'b0000_0000;
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            4'hf: abcdefgh = 8'b1000_1110;
        endcase
    end

    assign digit = sel;

endmodule

`default_nettype wire

/* source/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25
) (
    input  logic    clk,
    input  logic    rst,
    video_if.source video
);
    import board_pkg::*;

    localparam int pix_div = clk_mhz / pixel_mhz;
    localparam int w_pre   = pix_div > 1 ? $clog2(pix_div) : 1;

    logic [w_pre-1:0] pre_cnt;
    logic             pix_en;
    logic [w_x-1:0]   h_cnt;
    logic [w_x-1:0]   h_next;
    logic [w_y-1:0]   v_cnt;
    logic [w_y-1:0]   v_next;
    logic             hsync_q;
    logic             vsync_q;
    logic             display_on_q;

    // ------------------------------
    // Pixel prescaler
    // ------------------------------

    assign pix_en = pre_cnt == w_pre'(pix_div - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
        end else if (pix_en) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Raster counters
    // ------------------------------

    always_comb begin
        h_next = h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == w_x'(h_total - 1)) begin
            h_next = '0;  // End of line
            if (v_cnt == w_y'(v_total - 1)) begin
                v_next = '0;  // End of frame
            end else begin
                v_next = v_cnt + 1'b1;
            end
        end
    end

    // Syncs decoded from the next position so they line up with x and y
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt        <= '0;
            v_cnt        <= '0;
            hsync_q      <= 1'b1;
            vsync_q      <= 1'b1;
            display_on_q <= 1'b1;
        end else if (pix_en) begin
            h_cnt        <= h_next;
            v_cnt        <= v_next;
            hsync_q      <= !(h_next >= w_x'(h_sync_start) && h_next < w_x'(h_sync_end));
            vsync_q      <= !(v_next >= w_y'(v_sync_start) && v_next < w_y'(v_sync_end));
            display_on_q <= h_next < w_x'(h_visible) && v_next < w_y'(v_visible);
        end
    end

    assign video.x          = h_cnt;
    assign video.y          = v_cnt;
    assign video.hsync      = hsync_q;
    assign video.vsync      = vsync_q;
    assign video.display_on = display_on_q;

endmodule

`default_nettype wire

/* source/slow_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module slow_tick_gen #(
    parameter int clk_mhz = 50,
    parameter int tick_hz = 1
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int tick_period = clk_mhz * 1_000_000 / tick_hz;
    localparam int w_cnt       = tick_period > 1 ? $clog2(tick_period) : 1;

    logic [w_cnt-1:0] cnt;  // Cycles left until next tick

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= w_cnt'(tick_period - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= w_cnt'(tick_period - 1);  // Wrap and reload
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/video_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface video_if;
    import board_pkg::*;

    logic           hsync;       // Active low
    logic           vsync;       // Active low
    logic           display_on;  // Beam inside visible area
    logic [w_x-1:0] x;
    logic [w_y-1:0] y;

    modport source (output hsync, vsync, display_on, x, y);
    modport sink   (input  hsync, vsync, display_on, x, y);

endinterface

`default_nettype wire

/* source/board_pkg.sv */
`default_nettype none

package board_pkg;

    // ------------------------------
    // VGA 640x480 timing
    // ------------------------------

    localparam int h_visible = 640;  // Pixels
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;  // 800

    localparam int v_visible = 480;  // Lines
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;  // 525

    localparam int h_sync_start = h_visible + h_front;    // 656
    localparam int h_sync_end   = h_sync_start + h_sync;  // 752, first pixel after pulse
    localparam int v_sync_start = v_visible + v_front;    // 490
    localparam int v_sync_end   = v_sync_start + v_sync;  // 492

    localparam int w_x = 10;  // Enough for h_total
    localparam int w_y = 10;  // Enough for v_total

    // ------------------------------
    // Seven-segment display
    // ------------------------------

    localparam int w_digit         = 4;
    localparam int seg_scan_cycles = 16;  // Clock cycles per digit

    // Test pattern chosen by sw[1:0]
    typedef enum logic [1:0] {
        pattern_stripes = 2'd0,
        pattern_checker = 2'd1,
        pattern_solid   = 2'd2,
        pattern_off     = 2'd3
    } pattern_e;

    // I2S serializer states
    typedef enum logic [1:0] {
        i2s_idle  = 2'd0,
        i2s_left  = 2'd1,
        i2s_right = 2'd2
    } i2s_state_e;

endpackage

`default_nettype wire
